// ==== common/video_pkg.sv ====
package video_pkg;

    //////////////////////////////
    // input video format
    //////////////////////////////

    // one colour channel
    localparam int CHAN_W = 8;

    // full rgb word, three channels side by side
    localparam int PIX_W = 3 * CHAN_W;

    // one 24-bit pixel
    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [PIX_W-1:0] pixel_t;

    //////////////////////////////
    // decimation ratios
    //////////////////////////////

    // horizontal ratio
    // keep pixel 0, 4, 8 ... of each active line
    localparam int H_DECIM = 4;

    // vertical ratio
    // keep line 0, 4, 8 ... of each kept frame
    localparam int V_DECIM = 4;

    // temporal ratio
    // frame index mod 3 == 0 is captured, the other two are dropped
    localparam int FRAME_SKIP = 3;

    // the first frame after reset counts as index 0
    // so the very first frame is always a kept one

endpackage : video_pkg

// ==== common/capture_pkg.sv ====
package capture_pkg;

    //////////////////////////////
    // frame buffer geometry
    //////////////////////////////

    // stored image, after decimation
    localparam int STORE_COLS = 16;
    localparam int STORE_ROWS = 8;

    // one word per stored pixel
    localparam int BUF_DEPTH = STORE_COLS * STORE_ROWS;

    localparam int COL_W  = $clog2(STORE_COLS);
    localparam int ROW_W  = $clog2(STORE_ROWS);
    localparam int ADDR_W = $clog2(BUF_DEPTH);

    // linear address, row * STORE_COLS + col
    typedef logic [ADDR_W-1:0] buf_addr_t;
    typedef logic [COL_W-1:0]  col_t;
    typedef logic [ROW_W-1:0]  row_t;

    // mod-4 line and pixel phase
    typedef logic [1:0] phase_t;

    // mod-3 frame index
    typedef logic [1:0] frame_cnt_t;

    // decimator fsm
    typedef enum logic [1:0] {
        IDLE,
        SKIP_FRAME,
        CAPTURE,
        FULL
    } dec_state_t;

endpackage : capture_pkg

// ==== design/sync_detect.sv ====
`timescale 1ns/1ps

module sync_detect
    import video_pkg::*;
(
    input  logic   i_Clk,
    input  logic   i_rst,
    input  logic   i_hsync_n,
    input  logic   i_vsync_n,
    input  logic   i_vde,
    input  pixel_t i_pixel,
    output logic   o_line_start,
    output logic   o_frame_start,
    output logic   o_vde_q,
    output pixel_t o_pixel_q
);

    // syncs after inversion, active high
    logic hsync_q;
    logic vsync_q;

    // edge already taken for this sync pulse
    logic fallen_h;
    logic fallen_v;

    // inactive-to-active edge, only counted while blanking
    logic edge_h;
    logic edge_v;

    //////////////////////////////
    // input register stage
    //////////////////////////////

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
            o_vde_q <= 1'b0;
        end else begin
            hsync_q <= ~i_hsync_n;
            vsync_q <= ~i_vsync_n;
            o_vde_q <= i_vde;
        end
    end

    // pixel data just follows vde by one cycle
    always_ff @(posedge i_Clk) begin
        o_pixel_q <= i_pixel;
    end

    //////////////////////////////
    // edge flags and pulses
    //////////////////////////////

    assign edge_h = hsync_q && !fallen_h && !o_vde_q;
    assign edge_v = vsync_q && !fallen_v && !o_vde_q;

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            fallen_h      <= 1'b0;
            fallen_v      <= 1'b0;
            o_line_start  <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            // flag holds until the sync goes inactive again
            fallen_h      <= hsync_q && (fallen_h || !o_vde_q);
            fallen_v      <= vsync_q && (fallen_v || !o_vde_q);
            o_line_start  <= edge_h;
            o_frame_start <= edge_v;
        end
    end

endmodule : sync_detect

// ==== capture/pixel_decimator.sv ====
`timescale 1ns/1ps

module pixel_decimator
    import video_pkg::*;
    import capture_pkg::*;
(
    input  logic   i_Clk,
    input  logic   i_rst,
    input  logic   i_line_start,
    input  logic   i_frame_start,
    input  logic   i_vde,
    input  pixel_t i_pixel,
    output logic   o_wr_en,
    output pixel_t o_wr_data,
    output logic   o_line_kept,
    output col_t   o_col,
    output logic   o_frame_done
);

    dec_state_t state;
    frame_cnt_t frame_cnt;

    // line index mod V_DECIM, pixel index mod H_DECIM
    phase_t line_phase;
    phase_t pix_phase;

    // current line carried active pixels
    logic line_seen;
    // current line is one of the stored rows
    logic keep_line;

    row_t row;
    col_t col_cnt;
    // all STORE_COLS written on this line
    logic col_full;

    logic take_px;
    logic last_wr;
    logic next_kept;

    // sample picked when phase is 0 and the line still has room
    assign take_px = i_vde && !i_frame_start && !i_line_start
                     && (state == CAPTURE) && keep_line
                     && (pix_phase == '0) && !col_full;

    // write of the bottom right corner is going out now
    assign last_wr = o_wr_en && (row == row_t'(STORE_ROWS - 1))
                     && (o_col == col_t'(STORE_COLS - 1));

    // line that begins now lands on phase 0 with a row left
    assign next_kept = (state == CAPTURE) && (line_phase == phase_t'(V_DECIM - 1))
                       && (row != row_t'(STORE_ROWS - 1));

    //////////////////////////////
    // fsm and counters
    //////////////////////////////

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            state        <= IDLE;
            frame_cnt    <= '0;
            line_phase   <= '0;
            pix_phase    <= '0;
            line_seen    <= 1'b0;
            keep_line    <= 1'b0;
            row          <= '0;
            col_cnt      <= '0;
            col_full     <= 1'b0;
            o_col        <= '0;
            o_wr_en      <= 1'b0;
            o_line_kept  <= 1'b0;
            o_frame_done <= 1'b0;
        end else begin
            o_wr_en      <= 1'b0;
            o_line_kept  <= 1'b0;
            o_frame_done <= 1'b0;
            if (i_frame_start) begin
                // pick capture or skip from the frame index
                state      <= (frame_cnt == '0) ? CAPTURE : SKIP_FRAME;
                frame_cnt  <= (frame_cnt == frame_cnt_t'(FRAME_SKIP - 1)) ? '0 : frame_cnt + 1'b1;
                line_phase <= '0;
                pix_phase  <= '0;
                line_seen  <= 1'b0;
                row        <= '0;
                col_cnt    <= '0;
                col_full   <= 1'b0;
                // line 0 of a kept frame is row 0
                keep_line   <= (frame_cnt == '0);
                o_line_kept <= (frame_cnt == '0);
            end else if (i_line_start) begin
                pix_phase <= '0;
                col_cnt   <= '0;
                col_full  <= 1'b0;
                line_seen <= 1'b0;
                // blank lines in vertical blanking do not count
                if (line_seen) begin
                    line_phase  <= (line_phase == phase_t'(V_DECIM - 1)) ? '0 : line_phase + 1'b1;
                    keep_line   <= next_kept;
                    o_line_kept <= next_kept;
                    if (next_kept) begin
                        row <= row + 1'b1;
                    end
                end
            end else if (i_vde) begin
                line_seen <= 1'b1;
                pix_phase <= (pix_phase == phase_t'(H_DECIM - 1)) ? '0 : pix_phase + 1'b1;
                if (take_px) begin
                    o_wr_en <= 1'b1;
                    o_col   <= col_cnt;
                    if (col_cnt == col_t'(STORE_COLS - 1)) begin
                        col_full <= 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
            end
            // buffer is complete, rest of frame ignored
            if (last_wr) begin
                state        <= FULL;
                o_frame_done <= 1'b1;
            end
        end
    end

    // payload register, follows the strobe
    always_ff @(posedge i_Clk) begin
        if (take_px) begin
            o_wr_data <= i_pixel;
        end
    end

endmodule : pixel_decimator

// ==== capture/frame_addr_gen.sv ====
`timescale 1ns/1ps

module frame_addr_gen
    import video_pkg::*;
    import capture_pkg::*;
(
    input  logic      i_Clk,
    input  logic      i_rst,
    input  logic      i_frame_start,
    input  logic      i_line_kept,
    input  col_t      i_col,
    output buf_addr_t o_wr_addr
);

    // address of column 0 on the current stored row
    buf_addr_t line_base;

    // next kept line is row 0, base stays at 0
    logic first_line;

    // one stored row worth of words
    localparam buf_addr_t ROW_STEP = buf_addr_t'(STORE_COLS);

    // the line base is only meaningful while a frame is under way,
    // a new vsync edge always restarts it at the top of the buffer
    // even if the last frame stopped short of the bottom row

    //////////////////////////////
    // line base register
    //////////////////////////////

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            line_base  <= '0;
            first_line <= 1'b1;
        end else if (i_frame_start) begin
            line_base  <= '0;
            first_line <= 1'b1;
        end else if (i_line_kept) begin
            if (first_line) begin
                // row 0 keeps base 0
                first_line <= 1'b0;
            end else begin
                line_base <= line_base + ROW_STEP;
            end
        end
    end

    // row * STORE_COLS + col
    // col only counts up within a row, so no carry into the next row
    assign o_wr_addr = line_base + buf_addr_t'(i_col);

    // pixel timing keeps this combinational path safe, the base
    // settles during horizontal blanking before the first write

endmodule : frame_addr_gen

// ==== design/frame_buffer.sv ====
`timescale 1ns/1ps

module frame_buffer
    import video_pkg::*;
    import capture_pkg::*;
(
    input  logic      i_Clk,
    input  logic      i_wr_en,
    input  buf_addr_t i_wr_addr,
    input  pixel_t    i_wr_data,
    input  buf_addr_t i_rd_addr,
    output pixel_t    o_rd_data
);

    // one word per stored pixel
    // contents survive skipped frames
    pixel_t mem [BUF_DEPTH];

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge i_Clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // one cycle latency
    // same address as a write returns the old word
    always_ff @(posedge i_Clk) begin
        o_rd_data <= mem[i_rd_addr];
    end

    // both ports share i_Clk, the read side is free running
    // so later logic can scan the buffer at any time

endmodule : frame_buffer

// ==== design/video_capture_top.sv ====
`timescale 1ns/1ps

module video_capture_top
    import video_pkg::*;
    import capture_pkg::*;
(
    input  logic      i_Clk,
    input  logic      i_rst,
    input  logic      i_hsync_n,
    input  logic      i_vsync_n,
    input  logic      i_vde,
    input  pixel_t    i_pixel,
    input  buf_addr_t i_rd_addr,
    output pixel_t    o_rd_data,
    output logic      o_frame_start,
    output logic      o_frame_done
);

    // sync_detect outputs
    logic   line_start;
    logic   frame_start;
    logic   vde_q;
    pixel_t pixel_q;

    // decimator outputs
    logic   wr_en;
    pixel_t wr_data;
    logic   line_kept;
    col_t   col;

    // address generator output
    buf_addr_t wr_addr;

    //////////////////////////////
    // input side
    //////////////////////////////

    sync_detect sync_detect_i (
        .i_Clk         (i_Clk),
        .i_rst         (i_rst),
        .i_hsync_n     (i_hsync_n),
        .i_vsync_n     (i_vsync_n),
        .i_vde         (i_vde),
        .i_pixel       (i_pixel),
        .o_line_start  (line_start),
        .o_frame_start (frame_start),
        .o_vde_q       (vde_q),
        .o_pixel_q     (pixel_q)
    );

    pixel_decimator pixel_decimator_i (
        .i_Clk         (i_Clk),
        .i_rst         (i_rst),
        .i_line_start  (line_start),
        .i_frame_start (frame_start),
        .i_vde         (vde_q),
        .i_pixel       (pixel_q),
        .o_wr_en       (wr_en),
        .o_wr_data     (wr_data),
        .o_line_kept   (line_kept),
        .o_col         (col),
        .o_frame_done  (o_frame_done)
    );

    //////////////////////////////
    // storage side
    //////////////////////////////

    // line base restarts on every frame, kept or not
    frame_addr_gen frame_addr_gen_i (
        .i_Clk         (i_Clk),
        .i_rst         (i_rst),
        .i_frame_start (frame_start),
        .i_line_kept   (line_kept),
        .i_col         (col),
        .o_wr_addr     (wr_addr)
    );

    frame_buffer frame_buffer_i (
        .i_Clk     (i_Clk),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

    assign o_frame_start = frame_start;

endmodule : video_capture_top

// ==== verif/video_capture_sva.sv ====
`timescale 1ns/1ps

module video_capture_sva
    import capture_pkg::*;
(
    input logic       i_Clk,
    input logic       i_rst,
    input dec_state_t i_state,
    input logic       i_wr_en,
    input logic       i_frame_done,
    input col_t       i_col
);

    // assertion failure count
    int assert_fails = 0;

    // column of the most recent write
    col_t prev_col;

    always_ff @(posedge i_Clk) begin
        if (i_rst) begin
            prev_col <= '0;
        end else if (i_wr_en) begin
            prev_col <= i_col;
        end
    end

    //////////////////////////////
    // decimator properties
    //////////////////////////////

    // no write strobe while a frame is dropped or the buffer is full
    wr_state_ok: assert property (@(posedge i_Clk) disable iff (i_rst)
        i_wr_en |-> (i_state != SKIP_FRAME && i_state != FULL))
    else begin
        $error("write strobe high in state %0d", i_state);
        assert_fails = assert_fails + 1;
    end

    // frame done is one cycle wide
    done_pulse: assert property (@(posedge i_Clk) disable iff (i_rst)
        i_frame_done |=> !i_frame_done)
    else begin
        $error("frame done held for more than one cycle");
        assert_fails = assert_fails + 1;
    end

    // stored columns of a row are written left to right without a gap
    col_step: assert property (@(posedge i_Clk) disable iff (i_rst)
        (i_wr_en && i_col != '0) |-> (i_col == col_t'(prev_col + 1'b1)))
    else begin
        $error("column %0d written after column %0d", i_col, prev_col);
        assert_fails = assert_fails + 1;
    end

endmodule : video_capture_sva

bind pixel_decimator video_capture_sva video_capture_sva_i (
    .i_Clk        (i_Clk),
    .i_rst        (i_rst),
    .i_state      (state),
    .i_wr_en      (o_wr_en),
    .i_frame_done (o_frame_done),
    .i_col        (o_col)
);

// ==== verif/video_capture_tb.sv ====
`timescale 1ns/1ps

module video_capture_tb
    import video_pkg::*;
    import capture_pkg::*;
();

    // blanking lengths in clock cycles
    localparam int VS_LEN  = 3;
    localparam int VB_LEN  = 4;
    localparam int HS_LEN  = 2;
    localparam int HBP_LEN = 4;
    localparam int HFP_LEN = 2;
    localparam int N_TESTS = 4;
    localparam logic [31:0] LCG_SEED = 32'hd395;

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    // frames to send, active pixels per line, active lines, pixel seed
    int          tbl_frames [N_TESTS] = '{1, 2, 1, 3};
    int          tbl_width  [N_TESTS] = '{64, 64, 64, 96};
    int          tbl_lines  [N_TESTS] = '{32, 32, 32, 40};
    logic [31:0] tbl_seed   [N_TESTS] = '{32'h1111, 32'h2222, 32'h3333, 32'h4444};

    logic      i_Clk = 1'b0;
    logic      i_rst;
    logic      i_hsync_n;
    logic      i_vsync_n;
    logic      i_vde;
    pixel_t    i_pixel;
    buf_addr_t i_rd_addr;
    pixel_t    o_rd_data;
    logic      o_frame_start;
    logic      o_frame_done;

    // expected buffer image, last kept frame
    pixel_t exp_img [BUF_DEPTH];
    int     frame_idx = 0;
    int     start_cnt = 0;
    int     done_cnt  = 0;
    int     err_cnt   = 0;
    int     check_cnt = 0;

    video_capture_top video_capture_top_i (
        .i_Clk         (i_Clk),
        .i_rst         (i_rst),
        .i_hsync_n     (i_hsync_n),
        .i_vsync_n     (i_vsync_n),
        .i_vde         (i_vde),
        .i_pixel       (i_pixel),
        .i_rd_addr     (i_rd_addr),
        .o_rd_data     (o_rd_data),
        .o_frame_start (o_frame_start),
        .o_frame_done  (o_frame_done)
    );

    always #5 i_Clk = ~i_Clk;

    // pulse counters
    always @(posedge i_Clk) begin
        if (!i_rst && o_frame_start) start_cnt = start_cnt + 1;
        if (!i_rst && o_frame_done) done_cnt = done_cnt + 1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pixel for one position, mixed from seed, frame, line and pixel index
    function automatic pixel_t pixel_value(input logic [31:0] seed, input int frame_no,
                                           input int line_no, input int pix_no);
        logic [31:0] s;
        s = lcg_next(LCG_SEED ^ seed ^ (frame_no << 24) ^ (line_no << 12) ^ pix_no);
        s = lcg_next(s ^ (line_no << 4));
        return s[31:8];
    endfunction

    function automatic int frame_cycles(input int width, input int lines);
        return VS_LEN + VB_LEN + lines * (HS_LEN + HBP_LEN + width + HFP_LEN);
    endfunction

    // inputs change 1 ns after the edge
    task automatic tick();
        @(posedge i_Clk);
        #1;
    endtask

    task automatic drive(input logic hs_n, input logic vs_n, input logic de, input pixel_t pix);
        i_hsync_n = hs_n;
        i_vsync_n = vs_n;
        i_vde     = de;
        i_pixel   = pix;
        tick();
    endtask

    //////////////////////////////
    // frame generator
    //////////////////////////////

    task automatic send_frame(input logic [31:0] seed, input int width, input int lines);
        repeat (VS_LEN) drive(1'b1, 1'b0, 1'b0, '0);
        repeat (VB_LEN) drive(1'b1, 1'b1, 1'b0, '0);
        for (int l = 0; l < lines; l++) begin
            repeat (HS_LEN) drive(1'b0, 1'b1, 1'b0, '0);
            repeat (HBP_LEN) drive(1'b1, 1'b1, 1'b0, '0);
            for (int p = 0; p < width; p++) begin
                drive(1'b1, 1'b1, 1'b1, pixel_value(seed, frame_idx, l, p));
            end
            repeat (HFP_LEN) drive(1'b1, 1'b1, 1'b0, '0);
        end
        // kept frame: every 4th line, every 4th pixel, row * 16 + col
        if (frame_idx % FRAME_SKIP == 0) begin
            for (int r = 0; r < STORE_ROWS; r++) begin
                for (int c = 0; c < STORE_COLS; c++) begin
                    exp_img[r * STORE_COLS + c] = pixel_value(seed, frame_idx,
                                                              r * V_DECIM, c * H_DECIM);
                end
            end
        end
        frame_idx++;
    endtask

    // read port has one cycle latency
    task automatic check_buffer(input int test);
        for (int a = 0; a < BUF_DEPTH; a++) begin
            i_rd_addr = buf_addr_t'(a);
            tick();
            check_cnt++;
            if (o_rd_data !== exp_img[a]) begin
                err_cnt++;
                $display("Fail at %0t: test %0d addr %0d read %h expected %h",
                         $time, test, a, o_rd_data, exp_img[a]);
            end
        end
    endtask

    task automatic wait_done(input int target, input int limit);
        int waited;
        waited = 0;
        while (done_cnt < target && waited < limit) begin
            tick();
            waited++;
        end
        if (done_cnt < target) begin
            err_cnt++;
            $display("frame done pulse did not arrive within %0d cycles at %0t", limit, $time);
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int err_base;
        int done_base;
        int kept;
        int total_frames;
        int sva_fails;
        i_rst        = 1'b1;
        i_hsync_n    = 1'b1;
        i_vsync_n    = 1'b1;
        i_vde        = 1'b0;
        i_pixel      = '0;
        i_rd_addr    = '0;
        total_frames = 0;
        repeat (2) @(posedge i_Clk);
        #1;
        i_rst = 1'b0;
        // idle stream, no pulses expected
        for (int k = 0; k < 10; k++) begin
            tick();
            check_cnt++;
            if (o_frame_start !== 1'b0 || o_frame_done !== 1'b0) begin
                err_cnt++;
                $display("Fail at %0t: pulse seen before any frame", $time);
            end
        end
        $display("test 0: idle after reset, %0d errors", err_cnt);
        for (int t = 0; t < N_TESTS; t++) begin
            err_base  = err_cnt;
            done_base = done_cnt;
            kept      = 0;
            for (int f = 0; f < tbl_frames[t]; f++) begin
                if (frame_idx % FRAME_SKIP == 0) kept++;
                send_frame(tbl_seed[t], tbl_width[t], tbl_lines[t]);
            end
            total_frames += tbl_frames[t];
            repeat (4) drive(1'b1, 1'b1, 1'b0, '0);
            wait_done(done_base + kept, 20);
            check_cnt++;
            if (done_cnt != done_base + kept) begin
                err_cnt++;
                $display("Fail at %0t: test %0d frame done count %0d expected %0d",
                         $time, t + 1, done_cnt - done_base, kept);
            end
            check_buffer(t + 1);
            $display("test %0d: %0d frames of %0dx%0d, %0d kept, %0d errors", t + 1,
                     tbl_frames[t], tbl_width[t], tbl_lines[t], kept, err_cnt - err_base);
        end
        // one frame start per input frame over the run
        check_cnt++;
        if (start_cnt != total_frames) begin
            err_cnt++;
            $display("Fail at %0t: frame start count %0d expected %0d",
                     $time, start_cnt, total_frames);
        end
        sva_fails = video_capture_top_i.pixel_decimator_i.video_capture_sva_i.assert_fails;
        $display("checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt, sva_fails);
        if (err_cnt == 0 && sva_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, twice the cycle count of the whole table
    initial begin
        int budget;
        budget = 12;
        for (int t = 0; t < N_TESTS; t++) begin
            budget += tbl_frames[t] * frame_cycles(tbl_width[t], tbl_lines[t]) + BUF_DEPTH + 30;
        end
        repeat (budget * 2) @(posedge i_Clk);
        $display("watchdog expired after %0d cycles, the run did not finish", budget * 2);
        $display("Test failed");
        $finish;
    end

endmodule : video_capture_tb

// ==== video_capture.f ====
common/video_pkg.sv
common/capture_pkg.sv
design/sync_detect.sv
capture/pixel_decimator.sv
capture/frame_addr_gen.sv
design/frame_buffer.sv
design/video_capture_top.sv
verif/video_capture_sva.sv
verif/video_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the video capture testbench with verilator and run it
# the log is searched for the fail message to decide the result

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module video_capture_tb \
    -f video_capture.f -o video_capture_sim \
    || { echo "verilator build error"; exit 1; }

./obj_dir/video_capture_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "simulator returned a non-zero status" >> sim.log

cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; } || echo "no failure in log"
grep -q "Test completed successfully" sim.log || { echo "simulation ended early"; exit 1; }
